//--- common/l1i_pkg.sv
// Shared widths and types of the L1 instruction cache subsystem
// The fetch address is a union so the same word can be read raw
// or split into tag, set index, word offset and byte bits
// Imported by the cache core, the LRU, the refill unit and the top level
package l1i_pkg;

	// --------------------------------------------------
	// Widths
	// --------------------------------------------------
	localparam int ADDR_WIDTH   = 32;
	localparam int WORD_WIDTH   = 32;
	localparam int LINE_WORDS   = 4;
	localparam int LINE_WIDTH   = LINE_WORDS * WORD_WIDTH;
	// Word select inside a line
	localparam int OFFSET_WIDTH = 2;
	// 16 sets
	localparam int IDX_WIDTH    = 4;
	localparam int BYTE_WIDTH   = 2;
	localparam int TAG_WIDTH    = ADDR_WIDTH - IDX_WIDTH - OFFSET_WIDTH - BYTE_WIDTH;

	// --------------------------------------------------
	// Fetch address
	// --------------------------------------------------
	typedef struct packed {
		logic [TAG_WIDTH-1:0]    tag;
		logic [IDX_WIDTH-1:0]    idx;
		logic [OFFSET_WIDTH-1:0] offset;
		// Always zero for word fetches
		logic [BYTE_WIDTH-1:0]   byte_ofs;
	} l1i_addr_fields_s;

	typedef union packed {
		logic [ADDR_WIDTH-1:0] raw;
		l1i_addr_fields_s      fields;
	} l1i_addr_u;

	// Tag store word, one per way and set
	typedef struct packed {
		logic                 val;
		logic [TAG_WIDTH-1:0] tag;
	} l1i_tag_entry_s;

	// Miss request from the cache core to the refill unit
	typedef struct packed {
		l1i_addr_u addr;
	} l1i_line_req_s;

endpackage

//--- verilog/l1_reg_mem.sv
// Small register-array memory used for the cache tag and data stores
// Read is combinational, write happens on the clock edge with one
// enable bit per byte; a partial top byte is covered by the last bit
// Reset clears every entry so tag valid bits start at zero
module l1_reg_mem #(
	parameter int WIDTH = 32,
	parameter int DEPTH = 16
) (
	input  logic                       clk,
	input  logic                       arst_n,
	input  logic [$clog2(DEPTH)-1:0]   raddr,
	output logic [WIDTH-1:0]           rdata,
	input  logic                       wen,
	input  logic [$clog2(DEPTH)-1:0]   waddr,
	input  logic [WIDTH-1:0]           wdata,
	input  logic [(WIDTH+7)/8-1:0]     wbe
);

	logic [WIDTH-1:0] mem [DEPTH];

	// Asynchronous read port
	assign rdata = mem[raddr];

	always_ff @(posedge clk or negedge arst_n) begin
		if (!arst_n) begin
			for (int i = 0; i < DEPTH; i++) begin
				mem[i] <= '0;
			end
		end else if (wen) begin
			// Bit b belongs to byte lane b/8
			for (int b = 0; b < WIDTH; b++) begin
				if (wbe[b/8]) begin
					mem[waddr][b] <= wdata[b];
				end
			end
		end
	end

endmodule

//--- l1i/l1i_lru.sv
// Hit detection and victim choice for one cache set
// Each way of each set carries an age, 0 is most recent and
// WAY_NUM-1 is the least recently used
// On a hit the hitting way is returned, on a miss the first invalid way
// or else the oldest one; req marks the returned way as most recent
module l1i_lru #(
	parameter int WAY_NUM = 4
) (
	input  logic                                        clk,
	input  logic                                        arst_n,
	input  logic                                        req,
	input  logic [l1i_pkg::IDX_WIDTH-1:0]               idx,
	input  l1i_pkg::l1i_tag_entry_s [WAY_NUM-1:0]       tag_entries,
	input  logic [l1i_pkg::TAG_WIDTH-1:0]               req_tag,
	output logic                                        hit,
	output logic [WAY_NUM-1:0]                          way_vect
);

	import l1i_pkg::*;

	localparam int SET_NUM = 1 << IDX_WIDTH;
	localparam int AGE_W   = $clog2(WAY_NUM);

	logic [WAY_NUM-1:0][AGE_W-1:0] age_q [SET_NUM];
	logic [WAY_NUM-1:0][AGE_W-1:0] set_age;
	logic [WAY_NUM-1:0]            hit_vect;
	logic [WAY_NUM-1:0]            inv_vect;
	logic [WAY_NUM-1:0]            lru_vect;
	logic                          inv_found;
	logic [AGE_W-1:0]              sel_age;

	assign set_age = age_q[idx];

	// --------------------------------------------------
	// Way selection
	// --------------------------------------------------
	always_comb begin
		hit_vect  = '0;
		inv_vect  = '0;
		lru_vect  = '0;
		inv_found = 1'b0;
		for (int w = 0; w < WAY_NUM; w++) begin
			hit_vect[w] = tag_entries[w].val && (tag_entries[w].tag == req_tag);
			// Lowest numbered empty way wins
			if (!tag_entries[w].val && !inv_found) begin
				inv_vect[w] = 1'b1;
				inv_found   = 1'b1;
			end
			if (set_age[w] == AGE_W'(WAY_NUM - 1)) begin
				lru_vect[w] = 1'b1;
			end
		end
	end

	assign hit      = |hit_vect;
	assign way_vect = hit ? hit_vect : (inv_found ? inv_vect : lru_vect);

	// Age of the chosen way, ways younger than it get older
	always_comb begin
		sel_age = '0;
		for (int w = 0; w < WAY_NUM; w++) begin
			if (way_vect[w]) begin
				sel_age = set_age[w];
			end
		end
	end

	// --------------------------------------------------
	// Age update
	// --------------------------------------------------
	always_ff @(posedge clk or negedge arst_n) begin
		if (!arst_n) begin
			// Start from way order, way 0 youngest
			for (int s = 0; s < SET_NUM; s++) begin
				for (int w = 0; w < WAY_NUM; w++) begin
					age_q[s][w] <= AGE_W'(w);
				end
			end
		end else if (req) begin
			for (int w = 0; w < WAY_NUM; w++) begin
				if (way_vect[w]) begin
					age_q[idx][w] <= '0;
				end else if (set_age[w] < sel_age) begin
					age_q[idx][w] <= set_age[w] + 1'b1;
				end
			end
		end
	end

endmodule

//--- l1i/l1i_top.sv
// Cache core of the L1 instruction cache
// Splits the fetch address, looks up all tag and data ways at once and
// answers a hit in the same cycle
// A miss raises line_req_val with the line-aligned address and the fetch
// is answered straight from line_data when the refill unit acks
// The victim way is fixed on the first cycle of each fetch
module l1i_top #(
	parameter int WAY_NUM = 4
) (
	input  logic                             clk,
	input  logic                             arst_n,
	input  logic                             core_req_val,
	input  l1i_pkg::l1i_addr_u               core_req_addr,
	output logic                             core_req_ack,
	output logic [l1i_pkg::WORD_WIDTH-1:0]   core_ack_data,
	output logic                             line_req_val,
	output l1i_pkg::l1i_line_req_s           line_req,
	input  logic                             line_ack,
	input  logic [l1i_pkg::LINE_WIDTH-1:0]   line_data
);

	import l1i_pkg::*;

	localparam int SET_NUM   = 1 << IDX_WIDTH;
	localparam int TAG_MEM_W = $bits(l1i_tag_entry_s);

	logic [TAG_WIDTH-1:0]                  req_tag;
	logic [IDX_WIDTH-1:0]                  req_idx;
	logic [OFFSET_WIDTH-1:0]               req_offset;

	logic                                  req_val_q;
	logic                                  lru_req;
	logic                                  lru_hit;
	logic [WAY_NUM-1:0]                    lru_way_vect;
	logic [WAY_NUM-1:0]                    way_q;

	l1i_tag_entry_s [WAY_NUM-1:0]          tag_rd;
	l1i_tag_entry_s                        tag_wdata;
	logic [WAY_NUM-1:0][LINE_WIDTH-1:0]    data_rd;
	logic [WAY_NUM-1:0]                    fill_wen;
	logic [LINE_WIDTH-1:0]                 hit_line;
	logic [LINE_WIDTH-1:0]                 fetch_line;

	// Address split
	assign req_tag    = core_req_addr.fields.tag;
	assign req_idx    = core_req_addr.fields.idx;
	assign req_offset = core_req_addr.fields.offset;

	// --------------------------------------------------
	// First cycle of a fetch
	// --------------------------------------------------
	// High while a fetch is pending past its first cycle
	always_ff @(posedge clk or negedge arst_n) begin
		if (!arst_n) begin
			req_val_q <= 1'b0;
			way_q     <= '0;
		end else begin
			req_val_q <= core_req_val & ~core_req_ack;
			// Victim held for the whole miss
			if (lru_req) begin
				way_q <= lru_way_vect;
			end
		end
	end

	assign lru_req = core_req_val & ~req_val_q;

	// --------------------------------------------------
	// Core answer and miss request
	// --------------------------------------------------
	assign core_req_ack = core_req_val & (lru_hit | line_ack);
	assign line_req_val = core_req_val & ~lru_hit;

	always_comb begin
		line_req                       = '0;
		line_req.addr.fields.tag       = req_tag;
		line_req.addr.fields.idx       = req_idx;
	end

	// One-hot way mux
	always_comb begin
		hit_line = '0;
		for (int w = 0; w < WAY_NUM; w++) begin
			if (lru_way_vect[w]) begin
				hit_line |= data_rd[w];
			end
		end
	end

	assign fetch_line    = lru_hit ? hit_line : line_data;
	assign core_ack_data = fetch_line[req_offset*WORD_WIDTH +: WORD_WIDTH];

	// Fill writes go to the registered victim
	assign fill_wen      = way_q & {WAY_NUM{line_ack}};
	assign tag_wdata.val = 1'b1;
	assign tag_wdata.tag = req_tag;

	// --------------------------------------------------
	// Tag and data stores
	// --------------------------------------------------
	for (genvar w = 0; w < WAY_NUM; w++) begin : g_way
		l1_reg_mem #(
			.WIDTH (TAG_MEM_W),
			.DEPTH (SET_NUM)
		) tag_mem (
			.clk    (clk),
			.arst_n (arst_n),
			.raddr  (req_idx),
			.rdata  (tag_rd[w]),
			.wen    (fill_wen[w]),
			.waddr  (req_idx),
			.wdata  (tag_wdata),
			.wbe    ('1)
		);

		l1_reg_mem #(
			.WIDTH (LINE_WIDTH),
			.DEPTH (SET_NUM)
		) data_mem (
			.clk    (clk),
			.arst_n (arst_n),
			.raddr  (req_idx),
			.rdata  (data_rd[w]),
			.wen    (fill_wen[w]),
			.waddr  (req_idx),
			.wdata  (line_data),
			.wbe    ('1)
		);
	end

	l1i_lru #(
		.WAY_NUM (WAY_NUM)
	) lru (
		.clk         (clk),
		.arst_n      (arst_n),
		.req         (lru_req),
		.idx         (req_idx),
		.tag_entries (tag_rd),
		.req_tag     (req_tag),
		.hit         (lru_hit),
		.way_vect    (lru_way_vect)
	);

endmodule

//--- l1i/l1i_refill.sv
// Refill unit of the L1 instruction cache
// Turns one line request into LINE_WORDS single word reads on the
// memory bus, one outstanding at a time, at increasing word addresses
// Returned words shift into a line register with word 0 at the bottom
// line_ack pulses the cycle after the last word arrives
module l1i_refill (
	input  logic                             clk,
	input  logic                             arst_n,
	input  logic                             line_req_val,
	input  l1i_pkg::l1i_line_req_s           line_req,
	output logic                             line_ack,
	output logic [l1i_pkg::LINE_WIDTH-1:0]   line_data,
	output logic                             mem_req_val,
	output logic [l1i_pkg::ADDR_WIDTH-1:0]   mem_req_addr,
	input  logic                             mem_rsp_val,
	input  logic [l1i_pkg::WORD_WIDTH-1:0]   mem_rsp_data
);

	import l1i_pkg::*;

	typedef enum logic [1:0] {
		s_idle,
		s_issue,
		s_wait
	} refill_state_e;

	refill_state_e           state;
	logic [OFFSET_WIDTH-1:0] word_cnt;
	logic                    line_ack_q;
	logic [LINE_WIDTH-1:0]   line_q;
	l1i_addr_u               word_addr;

	// --------------------------------------------------
	// FSM and word counter
	// --------------------------------------------------
	always_ff @(posedge clk or negedge arst_n) begin
		if (!arst_n) begin
			state      <= s_idle;
			word_cnt   <= '0;
			line_ack_q <= 1'b0;
		end else begin
			line_ack_q <= 1'b0;
			case (state)
				s_idle: begin
					// Request is still high in the ack cycle
					if (line_req_val && !line_ack_q) begin
						state    <= s_issue;
						word_cnt <= '0;
					end
				end
				s_issue: state <= s_wait;
				s_wait: begin
					if (mem_rsp_val) begin
						word_cnt <= word_cnt + 1'b1;
						if (word_cnt == OFFSET_WIDTH'(LINE_WORDS - 1)) begin
							state      <= s_idle;
							line_ack_q <= 1'b1;
						end else begin
							state <= s_issue;
						end
					end
				end
				default: state <= s_idle;
			endcase
		end
	end

	// Newest word enters at the top
	always_ff @(posedge clk) begin
		if (state == s_wait && mem_rsp_val) begin
			line_q <= {mem_rsp_data, line_q[LINE_WIDTH-1:WORD_WIDTH]};
		end
	end

	// Word address inside the requested line
	always_comb begin
		word_addr                 = line_req.addr;
		word_addr.fields.offset   = word_cnt;
		word_addr.fields.byte_ofs = '0;
	end

	assign mem_req_val  = (state == s_issue);
	assign mem_req_addr = word_addr.raw;
	assign line_ack     = line_ack_q;
	assign line_data    = line_q;

endmodule

//--- verilog/l1i_subsys.sv
// RTL top level of the L1 instruction cache subsystem
// Core side is a level fetch request with a pulse ack, memory side is
// a one-word-at-a-time read bus; WAY_NUM sets the associativity
module l1i_subsys #(
	parameter int WAY_NUM = 4
) (
	input  logic                             clk,
	input  logic                             arst_n,
	// Core fetch port
	input  logic                             core_req_val,
	input  l1i_pkg::l1i_addr_u               core_req_addr,
	output logic                             core_req_ack,
	output logic [l1i_pkg::WORD_WIDTH-1:0]   core_ack_data,
	// Memory read port
	output logic                             mem_req_val,
	output logic [l1i_pkg::ADDR_WIDTH-1:0]   mem_req_addr,
	input  logic                             mem_rsp_val,
	input  logic [l1i_pkg::WORD_WIDTH-1:0]   mem_rsp_data
);

	import l1i_pkg::*;

	// Miss channel between core and refill unit
	logic                  line_req_val;
	l1i_line_req_s         line_req;
	logic                  line_ack;
	logic [LINE_WIDTH-1:0] line_data;

	l1i_top #(
		.WAY_NUM (WAY_NUM)
	) l1i_top_i (
		.clk           (clk),
		.arst_n        (arst_n),
		.core_req_val  (core_req_val),
		.core_req_addr (core_req_addr),
		.core_req_ack  (core_req_ack),
		.core_ack_data (core_ack_data),
		.line_req_val  (line_req_val),
		.line_req      (line_req),
		.line_ack      (line_ack),
		.line_data     (line_data)
	);

	l1i_refill l1i_refill_i (
		.clk          (clk),
		.arst_n       (arst_n),
		.line_req_val (line_req_val),
		.line_req     (line_req),
		.line_ack     (line_ack),
		.line_data    (line_data),
		.mem_req_val  (mem_req_val),
		.mem_req_addr (mem_req_addr),
		.mem_rsp_val  (mem_rsp_val),
		.mem_rsp_data (mem_rsp_data)
	);

endmodule

//--- test/tb_clk_gen.sv
// Clock and reset source of the testbench
// Clock toggles from time zero, reset is held low over RESET_CYCLES
// rising edges and released on a falling edge
module tb_clk_gen #(
	parameter int PERIOD       = 100,
	parameter int RESET_CYCLES = 2
) (
	output logic clk,
	output logic arst_n
);

	timeunit 1ns;
	timeprecision 1ps;

	initial begin
		clk = 1'b0;
		forever begin
			#(PERIOD / 2) clk = ~clk;
		end
	end

	// Release away from the rising edge
	initial begin
		arst_n = 1'b0;
		repeat (RESET_CYCLES) @(posedge clk);
		@(negedge clk);
		arst_n = 1'b1;
	end

endmodule

//--- test/l1i_assert.sv
// Concurrent checks on the cache core, bound into l1i_top
// Watches the tag match, the LRU way choice and both request handshakes
module l1i_assert #(
	parameter int WAY_NUM = 4
) (
	input logic                                  clk,
	input logic                                  arst_n,
	input logic                                  core_req_val,
	input logic                                  core_req_ack,
	input logic                                  line_req_val,
	input logic                                  line_ack,
	input l1i_pkg::l1i_tag_entry_s [WAY_NUM-1:0] tag_rd,
	input logic [l1i_pkg::TAG_WIDTH-1:0]         req_tag,
	input logic [WAY_NUM-1:0]                    way_vect
);

	timeunit 1ns;
	timeprecision 1ps;

	logic [WAY_NUM-1:0] match_vect;
	// Number of assertion failures so far
	int                 fired_cnt = 0;

	// Valid ways holding the fetch tag
	always_comb begin
		for (int w = 0; w < WAY_NUM; w++) begin
			match_vect[w] = tag_rd[w].val && (tag_rd[w].tag == req_tag);
		end
	end

	// --------------------------------------------------
	// Lookup
	// --------------------------------------------------
	one_way_match: assert property (@(posedge clk) disable iff (!arst_n)
		core_req_val |-> $onehot0(match_vect))
		else begin
			$error("more than one valid way holds the fetch tag");
			fired_cnt++;
		end

	way_onehot: assert property (@(posedge clk) disable iff (!arst_n)
		core_req_val |-> $onehot(way_vect))
		else begin
			$error("LRU way vector is not one-hot during a fetch");
			fired_cnt++;
		end

	// --------------------------------------------------
	// Handshakes
	// --------------------------------------------------
	// Every refill ack answers the waiting fetch
	line_ack_answers: assert property (@(posedge clk) disable iff (!arst_n)
		line_ack |-> core_req_ack)
		else begin
			$error("line ack without a core ack");
			fired_cnt++;
		end

	// Miss request stays up until the refill answers
	line_req_held: assert property (@(posedge clk) disable iff (!arst_n)
		(line_req_val && !line_ack) |=> line_req_val)
		else begin
			$error("line request dropped before line ack");
			fired_cnt++;
		end

endmodule

//--- test/l1i_tb.sv
// Testbench of the L1 instruction cache subsystem
// Replays the fetch trace, one test per line, against the DUT and a
// word-wide memory model with random response delays of 1 to 4 cycles
// Expected words and hit flags come from the trace file
// Run from the project root so the trace path resolves
module l1i_tb;

	timeunit 1ns;
	timeprecision 1ps;

	import l1i_pkg::*;

	localparam int    WAY_NUM    = 4;
	localparam int    CLK_PERIOD = 100;
	// Watchdog budget per trace line
	localparam int    WATCH_CYC  = 40;
	localparam string TRACE_FILE = "test/l1i_trace.txt";
	// Memory word is its address xor this pattern
	localparam logic [WORD_WIDTH-1:0] MEM_PATTERN = 32'h5a5a_0000;

	logic                  clk;
	logic                  arst_n;
	logic                  core_req_val;
	l1i_addr_u             core_req_addr;
	logic                  core_req_ack;
	logic [WORD_WIDTH-1:0] core_ack_data;
	logic                  mem_req_val;
	logic [ADDR_WIDTH-1:0] mem_req_addr;
	logic                  mem_rsp_val;
	logic [WORD_WIDTH-1:0] mem_rsp_data;

	// Trace contents, one entry per test
	string                 names[$];
	logic [ADDR_WIDTH-1:0] addrs[$];
	logic [WORD_WIDTH-1:0] exp_words[$];
	logic                  exp_hits[$];

	int     err_cnt      = 0;
	int     pass_cnt     = 0;
	int     fail_cnt     = 0;
	logic   trace_loaded = 1'b0;
	integer seed         = 32'h9bf5;

	tb_clk_gen #(
		.PERIOD       (CLK_PERIOD),
		.RESET_CYCLES (2)
	) clk_gen_i (
		.clk    (clk),
		.arst_n (arst_n)
	);

	l1i_subsys #(
		.WAY_NUM (WAY_NUM)
	) l1i_subsys_i (
		.clk           (clk),
		.arst_n        (arst_n),
		.core_req_val  (core_req_val),
		.core_req_addr (core_req_addr),
		.core_req_ack  (core_req_ack),
		.core_ack_data (core_ack_data),
		.mem_req_val   (mem_req_val),
		.mem_req_addr  (mem_req_addr),
		.mem_rsp_val   (mem_rsp_val),
		.mem_rsp_data  (mem_rsp_data)
	);

	bind l1i_top l1i_assert #(
		.WAY_NUM (WAY_NUM)
	) l1i_assert_i (
		.clk          (clk),
		.arst_n       (arst_n),
		.core_req_val (core_req_val),
		.core_req_ack (core_req_ack),
		.line_req_val (line_req_val),
		.line_ack     (line_ack),
		.tag_rd       (tag_rd),
		.req_tag      (req_tag),
		.way_vect     (lru_way_vect)
	);

	// --------------------------------------------------
	// Helpers
	// --------------------------------------------------
	task automatic check_value(input string test_name, input string what,
		input logic [31:0] expected, input logic [31:0] actual);
		if (actual !== expected) begin
			$display("FAILED %s %s: expected %h, actual %h", test_name, what, expected, actual);
			err_cnt++;
		end
	endtask

	// Lines starting with # and blank lines are skipped
	task automatic load_trace();
		integer           fd;
		logic [8*160-1:0] line_raw;
		logic [8*40-1:0]  name_raw;
		string            line_s;
		logic [31:0]      addr;
		logic [31:0]      word;
		logic [31:0]      hit;
		fd = $fopen(TRACE_FILE, "r");
		if (fd == 0) begin
			$display("ERROR: cannot open trace file %s", TRACE_FILE);
			err_cnt++;
			return;
		end
		while (!$feof(fd)) begin
			line_raw = '0;
			if ($fgets(line_raw, fd) == 0) begin
				break;
			end
			line_s = string'(line_raw);
			if (line_s.len() == 0 || line_s[0] == "#" || line_s[0] == "\n") begin
				continue;
			end
			name_raw = '0;
			if ($sscanf(line_s, "%s %h %h %h", name_raw, addr, word, hit) != 4) begin
				$display("ERROR: trace line cannot be parsed: %s", line_s);
				err_cnt++;
				continue;
			end
			names.push_back(string'(name_raw));
			addrs.push_back(addr);
			exp_words.push_back(word);
			exp_hits.push_back(hit[0]);
		end
		$fclose(fd);
		if (names.size() == 0) begin
			$display("ERROR: trace file holds no tests");
			err_cnt++;
		end
	endtask

	// One fetch, held until ack; hit means ack in the first cycle
	task automatic run_fetch(input int n);
		int                    cycles;
		int                    err_before;
		logic                  mem_seen;
		logic                  got_hit;
		logic [WORD_WIDTH-1:0] got_word;
		string                 status;
		string                 kind;
		cycles     = 0;
		mem_seen   = 1'b0;
		err_before = err_cnt;
		@(negedge clk);
		core_req_val      = 1'b1;
		core_req_addr.raw = addrs[n];
		// Values read at the edge are the ones the DUT samples
		do begin
			@(posedge clk);
			cycles++;
			if (mem_req_val) begin
				mem_seen = 1'b1;
			end
		end while (!core_req_ack);
		got_word = core_ack_data;
		got_hit  = (cycles == 1) && !mem_seen;
		check_value(names[n], "word", exp_words[n], got_word);
		check_value(names[n], "hit", 32'(exp_hits[n]), 32'(got_hit));
		if (err_cnt == err_before) begin
			pass_cnt++;
			status = "ok";
		end else begin
			fail_cnt++;
			status = "failed";
		end
		kind = got_hit ? "hit" : "miss";
		$display("test %0d %s: %s, tag=%h idx=%0d ofs=%0d, %s after %0d cycles", n, names[n],
			status, core_req_addr.fields.tag, core_req_addr.fields.idx,
			core_req_addr.fields.offset, kind, cycles);
	endtask

	// --------------------------------------------------
	// Memory bus model
	// --------------------------------------------------
	initial begin : mem_model
		logic [ADDR_WIDTH-1:0] rd_addr;
		int                    delay;
		mem_rsp_val  = 1'b0;
		mem_rsp_data = '0;
		@(posedge arst_n);
		forever begin
			@(posedge clk);
			if (mem_req_val) begin
				rd_addr = mem_req_addr;
				delay   = 1 + ($unsigned($random(seed)) % 4);
				// Only one read may be in flight
				repeat (delay - 1) begin
					@(posedge clk);
					if (mem_req_val) begin
						$display("ERROR: memory read issued while another is outstanding");
						err_cnt++;
					end
				end
				@(negedge clk);
				mem_rsp_val  = 1'b1;
				mem_rsp_data = rd_addr ^ MEM_PATTERN;
				@(negedge clk);
				mem_rsp_val  = 1'b0;
			end
		end
	end

	// --------------------------------------------------
	// Test sequence and watchdog
	// --------------------------------------------------
	initial begin : main
		core_req_val      = 1'b0;
		core_req_addr.raw = '0;
		load_trace();
		trace_loaded = 1'b1;
		@(posedge arst_n);
		// Next fetch starts in the cycle after each ack
		for (int n = 0; n < names.size(); n++) begin
			run_fetch(n);
		end
		@(negedge clk);
		core_req_val = 1'b0;
		repeat (2) @(posedge clk);
		err_cnt += l1i_subsys_i.l1i_top_i.l1i_assert_i.fired_cnt;
		$display("Summary: %0d tests, %0d passed, %0d failed, %0d errors", names.size(),
			pass_cnt, fail_cnt, err_cnt);
		if (err_cnt == 0) begin
			$display("Simulation finished: PASS");
		end else begin
			$display("Simulation finished: FAIL");
		end
		$finish;
	end

	initial begin : watchdog
		int budget;
		wait (trace_loaded);
		budget = (names.size() + 1) * WATCH_CYC;
		#(budget * CLK_PERIOD);
		$display("ERROR: watchdog expired after %0d cycles, trace not finished", budget);
		$display("Simulation finished: FAIL");
		$finish;
	end

endmodule

//--- l1i_subsys.f
common/l1i_pkg.sv
verilog/l1_reg_mem.sv
l1i/l1i_lru.sv
l1i/l1i_top.sv
l1i/l1i_refill.sv
verilog/l1i_subsys.sv
test/tb_clk_gen.sv
test/l1i_assert.sv
test/l1i_tb.sv

//--- Makefile
# Verilator build of the L1 instruction cache subsystem testbench
# Run from the project root, e.g. make run LOG=my.log

VERILATOR ?= verilator
TOP       ?= l1i_tb
FILELIST  ?= l1i_subsys.f
BUILD_DIR ?= obj_dir
LOG       ?= sim.log
VFLAGS    ?= --binary --timing --assert --timescale 1ns/1ps -j 0
PASS_MSG  ?= Simulation finished: PASS

SOURCES := $(shell grep -v '^+' $(FILELIST))
SIM_BIN := $(BUILD_DIR)/V$(TOP)

.PHONY: all compile run clean

all: run

compile: $(SIM_BIN)

$(SIM_BIN): $(FILELIST) $(SOURCES)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -Mdir $(BUILD_DIR) -f $(FILELIST)

# The log decides the result, a missing pass line fails the target
run: compile
	./$(SIM_BIN) | tee $(LOG)
	@grep -q "$(PASS_MSG)" $(LOG) || (echo "run failed, see $(LOG)"; exit 1)

clean:
	rm -rf $(BUILD_DIR) $(LOG)

//--- test/l1i_trace.txt
# test_name fetch_addr expected_word expected_hit
# address and word in hex, hit 1 or miss 0, expectations assume 4 ways with LRU
cold_miss         00001000 5a5a1000 0
line_hit_w1       00001004 5a5a1004 1
line_hit_w2       00001008 5a5a1008 1
line_hit_w3       0000100c 5a5a100c 1
line_hit_w0       00001000 5a5a1000 1
fill_tag_a        00002030 5a5a2030 0
fill_tag_b        00002134 5a5a2134 0
fill_tag_c        00002238 5a5a2238 0
fill_tag_d        0000233c 5a5a233c 0
resident_a        00002030 5a5a2030 1
resident_b        00002134 5a5a2134 1
resident_c        00002238 5a5a2238 1
resident_d        0000233c 5a5a233c 1
touch_a           00002034 5a5a2034 1
evict_b_by_e      00002430 5a5a2430 0
refetch_b         00002130 5a5a2130 0
keep_a            00002038 5a5a2038 1
refetch_c         00002230 5a5a2230 0
keep_e            0000243c 5a5a243c 1
refetch_d         00002330 5a5a2330 0
keep_a_again      00002034 5a5a2034 1
b_was_evicted     00002138 5a5a2138 0
other_set_kept    0000100c 5a5a100c 1
miss_after_hit    00003050 5a5a3050 0
hit_after_miss    00003054 5a5a3054 1
miss_then_miss_a  00004060 5a5a4060 0
miss_then_miss_b  00005070 5a5a5070 0
hit_back          00004064 5a5a4064 1
